//--- verilog/bus_pkg.sv
`default_nettype none

package bus_pkg;

	// Data path word
	localparam int WORD_W = 32;

	typedef logic [WORD_W-1:0] word_t;

	// Byte lanes per word
	localparam int SEL_W = WORD_W / 8;

	// Word access on every transfer
	localparam logic [SEL_W-1:0] SEL_ALL = '1;

endpackage

`default_nettype wire

//--- verilog/isa_pkg.sv
`default_nettype none

package isa_pkg;

	localparam int OPC_W = 5;
	localparam int REG_IDX_W = 4;
	localparam int IMM_W = 19;

	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// Opcodes in bits 31:27
	localparam logic [OPC_W-1:0] OP_LD = 5'd0;
	localparam logic [OPC_W-1:0] OP_LDI = 5'd1;
	localparam logic [OPC_W-1:0] OP_ST = 5'd2;
	localparam logic [OPC_W-1:0] OP_ADD = 5'd3;

	// ld, ldi, st
	typedef struct packed {
		logic [OPC_W-1:0] opcode;
		reg_idx_t ra;
		reg_idx_t rb;
		logic [IMM_W-1:0] imm;
	} mem_fmt_t;

	// add, rc sits in the top of the constant field
	typedef struct packed {
		logic [OPC_W-1:0] opcode;
		reg_idx_t ra;
		reg_idx_t rb;
		reg_idx_t rc;
		logic [IMM_W-REG_IDX_W-1:0] unused;
	} reg_fmt_t;

	typedef union packed {
		mem_fmt_t mem_fmt;
		reg_fmt_t reg_fmt;
	} instr_u;

	typedef enum logic [2:0] {
		CLS_NOP, CLS_LOAD, CLS_LOAD_IMM, CLS_STORE, CLS_ADD
	} op_class_e;

endpackage

`default_nettype wire

//--- verilog/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
	input wire clk,
	input wire rst_n,
	input wire we,
	input wire isa_pkg::reg_idx_t waddr,
	input wire isa_pkg::reg_idx_t raddr_a,
	input wire isa_pkg::reg_idx_t raddr_b,
	input wire bus_pkg::word_t wdata,
	output bus_pkg::word_t rd_a,
	output bus_pkg::word_t rd_b
);

	localparam int NUM_REGS = 2 ** isa_pkg::REG_IDX_W;

	bus_pkg::word_t regs [NUM_REGS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[waddr] <= wdata;
		end
	end

	// Reads see the old value during a write cycle
	assign rd_a = regs[raddr_a];
	assign rd_b = regs[raddr_b];

endmodule

`default_nettype wire

//--- verilog/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
	input wire clk,
	input wire rst_n,
	input wire z_load,
	input wire base_zero,
	input wire use_imm,
	input wire bus_pkg::word_t rd_a,
	input wire bus_pkg::word_t rd_b,
	input wire bus_pkg::word_t imm,
	output bus_pkg::word_t z
);

	bus_pkg::word_t op_a;
	bus_pkg::word_t op_b;
	bus_pkg::word_t sum;

	// Base register or zero
	assign op_a = base_zero ? '0 : rd_a;

	// Constant for memory formats, Rc for add
	assign op_b = use_imm ? imm : rd_b;

	assign sum = op_a + op_b; // Carry out dropped

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			z <= '0;
		else if (z_load)
			z <= sum;
	end

endmodule

`default_nettype wire

//--- verilog/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
	input wire clk,
	input wire rst_n,
	input wire ir_load,
	input wire bus_pkg::word_t instr,
	output isa_pkg::op_class_e op_class,
	output isa_pkg::reg_idx_t ra,
	output isa_pkg::reg_idx_t rb,
	output isa_pkg::reg_idx_t rc, // Second read port index
	output bus_pkg::word_t imm,
	output logic base_zero,
	output logic use_imm
);

	isa_pkg::instr_u ir;
	logic is_add;
	logic is_mem;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ir <= '0;
		else if (ir_load)
			ir <= instr;
	end

	always_comb begin
		case (ir.mem_fmt.opcode)
			isa_pkg::OP_LD: op_class = isa_pkg::CLS_LOAD;
			isa_pkg::OP_LDI: op_class = isa_pkg::CLS_LOAD_IMM;
			isa_pkg::OP_ST: op_class = isa_pkg::CLS_STORE;
			isa_pkg::OP_ADD: op_class = isa_pkg::CLS_ADD;
			default: op_class = isa_pkg::CLS_NOP; // Unknown opcodes fall through
		endcase
	end

	assign is_add = (op_class == isa_pkg::CLS_ADD);
	assign is_mem = (op_class == isa_pkg::CLS_LOAD) || (op_class == isa_pkg::CLS_LOAD_IMM) ||
		(op_class == isa_pkg::CLS_STORE);

	// Ra and Rb sit at the same bits in both formats
	assign ra = ir.mem_fmt.ra;
	assign rb = ir.mem_fmt.rb;
	assign rc = is_add ? ir.reg_fmt.rc : ra; // Ra feeds the store data

	// Sign extend the 19-bit constant
	assign imm = {{(bus_pkg::WORD_W - isa_pkg::IMM_W){ir.mem_fmt.imm[isa_pkg::IMM_W-1]}},
		ir.mem_fmt.imm};

	assign base_zero = is_mem && (ir.mem_fmt.rb == '0); // R0 as base means no base
	assign use_imm = is_mem;

	// An unknown opcode would otherwise decode silently as a no-op
	a_class_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(ir.mem_fmt.opcode));

endmodule

`default_nettype wire

//--- verilog/step_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module step_sequencer #(
	parameter int ADDR_W = 9,
	parameter logic [ADDR_W-1:0] RESET_PC = '0
) (
	input wire clk,
	input wire rst_n,
	input wire isa_pkg::op_class_e op_class,
	input wire bus_pkg::word_t z,
	input wire bus_pkg::word_t store_data,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output logic [ADDR_W-1:0] wb_adr,
	output bus_pkg::word_t wb_dat_o,
	output logic [3:0] wb_sel,
	input wire bus_pkg::word_t wb_dat_i,
	input wire wb_ack,
	output logic ir_load,
	output logic z_load,
	output logic rf_we,
	output bus_pkg::word_t rf_wdata
);

	typedef enum logic [2:0] {
		FETCH, DECODE, EXECUTE, MEMORY, WRITEBACK
	} state_e;

	state_e state;
	state_e state_nxt;
	logic [ADDR_W-1:0] pc;
	bus_pkg::word_t mdr;
	logic req; // Transfer outstanding on the bus
	logic bus_done;
	logic bus_start;
	logic mem_op;

	assign mem_op = (op_class == isa_pkg::CLS_LOAD) || (op_class == isa_pkg::CLS_STORE);
	assign bus_done = req && wb_ack;

	// Request goes up on the edge that enters FETCH or MEMORY.
	// FETCH without a request only happens right after reset.
	assign bus_start = (state == WRITEBACK) || (state == EXECUTE && mem_op) ||
		(state == FETCH && !req);

	always_comb begin
		state_nxt = state;
		case (state)
			FETCH: if (bus_done) state_nxt = DECODE;
			DECODE: state_nxt = EXECUTE;
			EXECUTE: state_nxt = mem_op ? MEMORY : WRITEBACK;
			MEMORY: if (bus_done) state_nxt = WRITEBACK;
			WRITEBACK: state_nxt = FETCH;
			default: state_nxt = FETCH;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= FETCH;
			req <= 1'b0;
		end else begin
			state <= state_nxt;
			if (bus_done)
				req <= 1'b0;
			else if (bus_start)
				req <= 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= RESET_PC;
			mdr <= '0;
		end else begin
			if (state == FETCH && bus_done)
				pc <= pc + 1'b1; // Next word
			if (state == MEMORY && bus_done && op_class == isa_pkg::CLS_LOAD)
				mdr <= wb_dat_i;
		end
	end

	// Wishbone master side
	assign wb_cyc = req;
	assign wb_stb = req;
	assign wb_we = (state == MEMORY) && (op_class == isa_pkg::CLS_STORE);
	assign wb_adr = (state == MEMORY) ? z[ADDR_W-1:0] : pc;
	assign wb_dat_o = store_data;
	assign wb_sel = bus_pkg::SEL_ALL;

	// Datapath strobes
	assign ir_load = (state == FETCH) && bus_done;
	assign z_load = (state == EXECUTE);
	assign rf_we = (state == WRITEBACK) && ((op_class == isa_pkg::CLS_LOAD) ||
		(op_class == isa_pkg::CLS_LOAD_IMM) || (op_class == isa_pkg::CLS_ADD));
	assign rf_wdata = (op_class == isa_pkg::CLS_LOAD) ? mdr : z;

	// Bus only active in the two transfer steps
	a_stb_cyc: assert property (@(posedge clk) disable iff (!rst_n)
		wb_stb |-> wb_cyc && (state == FETCH || state == MEMORY));

	// Address, direction and strobe hold through wait states
	a_adr_hold: assert property (@(posedge clk) disable iff (!rst_n)
		wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we));

endmodule

`default_nettype wire

//--- verilog/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core #(
	parameter int ADDR_W = 9,
	parameter logic [ADDR_W-1:0] RESET_PC = '0
) (
	input wire clk,
	input wire rst_n,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output logic [ADDR_W-1:0] wb_adr,
	output bus_pkg::word_t wb_dat_o,
	output logic [3:0] wb_sel,
	input wire bus_pkg::word_t wb_dat_i,
	input wire wb_ack
);

	isa_pkg::op_class_e op_class;
	isa_pkg::reg_idx_t ra;
	isa_pkg::reg_idx_t rb;
	isa_pkg::reg_idx_t rc;
	bus_pkg::word_t imm;
	bus_pkg::word_t rd_a;
	bus_pkg::word_t rd_b;
	bus_pkg::word_t z;
	bus_pkg::word_t rf_wdata;
	logic ir_load;
	logic z_load;
	logic rf_we;
	logic base_zero;
	logic use_imm;

	step_sequencer #(
		.ADDR_W(ADDR_W),
		.RESET_PC(RESET_PC)
	) u_seq (
		.clk(clk),
		.rst_n(rst_n),
		.op_class(op_class),
		.z(z),
		.store_data(rd_b), // Ra comes out of the second read port
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_o(wb_dat_o),
		.wb_sel(wb_sel),
		.wb_dat_i(wb_dat_i),
		.wb_ack(wb_ack),
		.ir_load(ir_load),
		.z_load(z_load),
		.rf_we(rf_we),
		.rf_wdata(rf_wdata)
	);

	instr_decode u_dec (
		.clk(clk),
		.rst_n(rst_n),
		.ir_load(ir_load),
		.instr(wb_dat_i),
		.op_class(op_class),
		.ra(ra),
		.rb(rb),
		.rc(rc),
		.imm(imm),
		.base_zero(base_zero),
		.use_imm(use_imm)
	);

	register_file u_rf (
		.clk(clk),
		.rst_n(rst_n),
		.we(rf_we),
		.waddr(ra),
		.raddr_a(rb),
		.raddr_b(rc),
		.wdata(rf_wdata),
		.rd_a(rd_a),
		.rd_b(rd_b)
	);

	execute_unit u_exe (
		.clk(clk),
		.rst_n(rst_n),
		.z_load(z_load),
		.base_zero(base_zero),
		.use_imm(use_imm),
		.rd_a(rd_a),
		.rd_b(rd_b),
		.imm(imm),
		.z(z)
	);

endmodule

`default_nettype wire

//--- testbench/cpu_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core_tb;

	localparam int ADDR_W = 9;
	localparam logic [ADDR_W-1:0] RESET_PC = '0;
	localparam int MEM_WORDS = 2 ** ADDR_W;
	localparam int RESET_CYCLES = 16;
	localparam int CYCLES_PER_INSTR = 40;
	localparam time DRIVE_DELAY = 10;

	logic clk;
	logic rst_n;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [ADDR_W-1:0] wb_adr;
	bus_pkg::word_t wb_dat_o;
	logic [3:0] wb_sel;
	bus_pkg::word_t wb_dat_i;
	logic wb_ack;

	bus_pkg::word_t mem [MEM_WORDS];
	logic [ADDR_W-1:0] exp_adr [$]; // Expected stores in order
	bus_pkg::word_t exp_dat [$];
	integer seed = 32'hddfe_4e61;
	int instr_count;
	int cycles;
	int wait_left;
	logic [ADDR_W-1:0] held_adr;
	bit busy; // Slave has a transfer pending
	bit first_seen;
	bit stores_done;

	cpu_core #(
		.ADDR_W(ADDR_W),
		.RESET_PC(RESET_PC)
	) UUT (
		.clk(clk),
		.rst_n(rst_n),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_o(wb_dat_o),
		.wb_sel(wb_sel),
		.wb_dat_i(wb_dat_i),
		.wb_ack(wb_ack)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic load_trace();
		int fd;
		int n;
		string line;
		logic [7:0] kind;
		logic [31:0] adr;
		logic [31:0] dat;
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = 32'ha5a5_0000 ^ i; // Unloaded words decode as no-ops
		fd = $fopen("testbench/cpu_core_trace.txt", "r");
		if (fd == 0)
			stop_run("Could not open testbench/cpu_core_trace.txt");
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line[0] == "#")
				continue;
			n = $sscanf(line, "%c %h %h", kind, adr, dat);
			assert (n == 3 && (kind == "M" || kind == "W"))
			else stop_run({"Trace line could not be read: ", line});
			if (kind == "M") begin
				mem[adr[ADDR_W-1:0]] = dat;
				instr_count++; // Data words only add margin
			end else begin
				exp_adr.push_back(adr[ADDR_W-1:0]);
				exp_dat.push_back(dat);
			end
		end
		$fclose(fd);
	endtask

	task automatic check_idle(input string when_txt);
		assert (wb_cyc === 1'b0 && wb_stb === 1'b0 && wb_we === 1'b0)
		else stop_run($sformatf("ERR %0t bus not idle %s (cyc %b stb %b we %b)",
			$time, when_txt, wb_cyc, wb_stb, wb_we));
	endtask

	task automatic check_store();
		logic [ADDR_W-1:0] adr;
		bus_pkg::word_t dat;
		assert (exp_adr.size() > 0)
		else stop_run("A store arrived after the last expected store");
		adr = exp_adr.pop_front();
		dat = exp_dat.pop_front();
		assert (wb_adr == adr && wb_dat_o == dat)
		else stop_run($sformatf("ERR %0t store to %h data %h, expected %h data %h",
			$time, wb_adr, wb_dat_o, adr, dat));
		assert (wb_sel == 4'hf)
		else stop_run($sformatf("ERR %0t store byte select %b, expected 1111", $time, wb_sel));
		mem[wb_adr] = wb_dat_o;
		if (exp_adr.size() == 0)
			stores_done = 1'b1;
	endtask

	task automatic serve_transfer();
		if (!first_seen) begin
			first_seen = 1'b1;
			assert (!wb_we && wb_adr == RESET_PC)
			else stop_run($sformatf("ERR %0t first transfer we %b adr %h, expected read of %h",
				$time, wb_we, wb_adr, RESET_PC));
		end
		if (wb_we)
			check_store();
		else
			wb_dat_i = mem[wb_adr];
	endtask

	// Wishbone slave with 0 to 3 wait states
	initial begin
		forever begin
			@(posedge clk);
			#DRIVE_DELAY;
			if (wb_ack) begin
				wb_ack = 1'b0; // Ack lasts one cycle
			end else if (rst_n && wb_cyc && wb_stb) begin
				if (!busy) begin
					busy = 1'b1;
					held_adr = wb_adr;
					wait_left = $random(seed) & 3;
				end else begin
					assert (wb_adr == held_adr)
					else stop_run($sformatf("ERR %0t address moved from %h to %h during wait",
						$time, held_adr, wb_adr));
				end
				if (wait_left == 0) begin
					serve_transfer();
					busy = 1'b0;
					wb_ack = 1'b1;
				end else begin
					wait_left--;
				end
			end
		end
	end

	initial begin
		rst_n = 1'b0;
		wb_ack = 1'b0;
		wb_dat_i = '0;
		load_trace();
		repeat (RESET_CYCLES) begin
			@(posedge clk);
			#DRIVE_DELAY;
			check_idle("during reset");
		end
		rst_n = 1'b1;
		#1 check_idle("after reset release");
		while (!stores_done && cycles < CYCLES_PER_INSTR * instr_count) begin
			@(posedge clk);
			cycles++;
		end
		if (stores_done) begin
			$display("All checks passed");
			$finish;
		end else begin
			stop_run($sformatf("Timeout after %0d cycles, %0d expected stores never arrived",
				cycles, exp_adr.size()));
		end
	end

endmodule

`default_nettype wire

//--- cpu_core.f
verilog/bus_pkg.sv
verilog/isa_pkg.sv
verilog/register_file.sv
verilog/execute_unit.sv
verilog/instr_decode.sv
verilog/step_sequencer.sv
verilog/cpu_core.sv
testbench/cpu_core_tb.sv

//--- testbench/cpu_core_trace.txt
# M word_address data : memory preload, program from address 0, data after it
# W word_address data : expected store transfers, in bus order
M 000 0887FFFB
M 001 10800040
M 002 09000020
M 003 01900010
M 004 11900022
M 005 02100011
M 006 02900012
M 007 1B228000
M 008 13000041
M 009 F8000000
M 00A 0B83FFFF
M 00B 0C0FFFF0
M 00C 1CBC0000
M 00D 14900003
M 00E 1417FFFE
M 030 12345678
M 031 FFFFFFF0
M 032 00000025
W 040 FFFFFFFB
W 042 12345678
W 041 00000015
W 023 0003FFEA
W 01E FFFFFFEB
